//--- id_config.svh
`default_nettype none

`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// Data path and PC width
`define ID_DATA_W 32

// Architectural registers
`define ID_REG_COUNT 32

// Bundles that may be in flight toward execute
`define ID_CREDITS 2

`endif

`default_nettype wire

//--- id_pkg.sv
`include "id_config.svh"
`default_nettype none

package id_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_PASS   // Forward source A untouched
    } alu_op_e;

    typedef enum logic [1:0] {
        EXT_ZERO,
        EXT_SIGN,
        EXT_UPPER
    } ext_mode_e;

    typedef enum logic [1:0] {
        SRC_A_PC,   // Link value for JAL
        SRC_A_RS,
        SRC_A_IMM,
        SRC_A_ZERO
    } src_a_sel_e;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [`ID_DATA_W-1:0] alu_a;
        logic [`ID_DATA_W-1:0] alu_b;
        logic [`ID_DATA_W-1:0] agu_addr;
        logic [25:0]           addr_offset;  // Jump target or branch imm in [15:0]
        logic [4:0]            dest;
        logic                  wr_en;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  branch;
        logic                  branch_ne;
        logic                  jump;
        logic                  link;
        logic                  illegal;
    } id_bundle_t;

endpackage

`default_nettype wire

//--- id_ctrl_if.sv
`default_nettype none

interface id_ctrl_if import id_pkg::*; ();

    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  sa;         // Shift amount field
    logic [15:0] imm;
    ext_mode_e   ext_mode;
    src_a_sel_e  src_a_sel;
    logic        src_b_sa;   // ALU B takes sa instead of rt data
    logic        agu_pc;     // Address operand from PC

    modport ctrl (
        output rs,
        output rt,
        output sa,
        output imm,
        output ext_mode,
        output src_a_sel,
        output src_b_sa,
        output agu_pc
    );

    modport sel (
        input sa,
        input imm,
        input ext_mode,
        input src_a_sel,
        input src_b_sa,
        input agu_pc
    );

endinterface

`default_nettype wire

//--- id_control_unit.sv
`default_nettype none

module id_control_unit import id_pkg::*; (
    input  wire [31:0]  i_instr,
    id_ctrl_if.ctrl     ctrl,
    output logic [4:0]  o_rd_dest,
    output alu_op_e     o_alu_op,
    output logic        o_wr_en,
    output logic        o_mem_rd,
    output logic        o_mem_wr,
    output logic        o_branch,
    output logic        o_branch_ne,
    output logic        o_jump,
    output logic        o_link,
    output logic        o_illegal,
    output logic [25:0] o_addr_offset
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;
    logic [4:0] rd;

    assign opcode        = i_instr[31:26];
    assign funct         = i_instr[5:0];
    assign rt            = i_instr[20:16];
    assign rd            = i_instr[15:11];
    assign ctrl.rs       = i_instr[25:21];
    assign ctrl.rt       = rt;
    assign ctrl.sa       = i_instr[10:6];
    assign ctrl.imm      = i_instr[15:0];
    assign o_addr_offset = i_instr[25:0];

    always_comb begin
        o_rd_dest      = rt;   // I-type default
        o_alu_op       = ALU_PASS;
        o_wr_en        = 1'b0;
        o_mem_rd       = 1'b0;
        o_mem_wr       = 1'b0;
        o_branch       = 1'b0;
        o_branch_ne    = 1'b0;
        o_jump         = 1'b0;
        o_link         = 1'b0;
        o_illegal      = 1'b0;
        ctrl.ext_mode  = EXT_SIGN;
        ctrl.src_a_sel = SRC_A_RS;
        ctrl.src_b_sa  = 1'b0;
        ctrl.agu_pc    = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                o_rd_dest = rd;
                o_wr_en   = 1'b1;
                case (funct)
                    FN_ADDU: o_alu_op = ALU_ADD;
                    FN_SUBU: o_alu_op = ALU_SUB;
                    FN_AND:  o_alu_op = ALU_AND;
                    FN_OR:   o_alu_op = ALU_OR;
                    FN_XOR:  o_alu_op = ALU_XOR;
                    FN_SLT:  o_alu_op = ALU_SLT;
                    FN_SLL: begin
                        o_alu_op      = ALU_SLL;
                        ctrl.src_b_sa = 1'b1;
                    end
                    FN_SRL: begin
                        o_alu_op      = ALU_SRL;
                        ctrl.src_b_sa = 1'b1;
                    end
                    FN_JR: begin
                        o_wr_en        = 1'b0;
                        o_jump         = 1'b1;   // Target is rs data on AGU
                        ctrl.src_a_sel = SRC_A_ZERO;
                    end
                    default: o_illegal = 1'b1;
                endcase
            end
            OP_ADDIU: begin
                o_alu_op       = ALU_ADD;
                o_wr_en        = 1'b1;
                ctrl.src_a_sel = SRC_A_IMM;
            end
            OP_ANDI: begin
                o_alu_op       = ALU_AND;
                o_wr_en        = 1'b1;
                ctrl.ext_mode  = EXT_ZERO;
                ctrl.src_a_sel = SRC_A_IMM;
            end
            OP_ORI: begin
                o_alu_op       = ALU_OR;
                o_wr_en        = 1'b1;
                ctrl.ext_mode  = EXT_ZERO;
                ctrl.src_a_sel = SRC_A_IMM;
            end
            OP_LUI: begin
                o_alu_op       = ALU_LUI;
                o_wr_en        = 1'b1;
                ctrl.ext_mode  = EXT_UPPER;
                ctrl.src_a_sel = SRC_A_IMM;
            end
            OP_LW: begin
                o_alu_op       = ALU_ADD;
                o_wr_en        = 1'b1;
                o_mem_rd       = 1'b1;
                ctrl.src_a_sel = SRC_A_IMM;
            end
            OP_SW: begin
                o_alu_op       = ALU_ADD;
                o_mem_wr       = 1'b1;   // Store data rides on ALU B
                ctrl.src_a_sel = SRC_A_IMM;
            end
            OP_BEQ, OP_BNE: begin
                o_alu_op    = ALU_SUB;   // Compare rs against rt
                o_branch    = 1'b1;
                o_branch_ne = (opcode == OP_BNE);
                ctrl.agu_pc = 1'b1;
            end
            OP_J: begin
                o_rd_dest      = 5'd0;
                o_jump         = 1'b1;
                ctrl.src_a_sel = SRC_A_ZERO;
                ctrl.agu_pc    = 1'b1;
            end
            OP_JAL: begin
                o_rd_dest      = 5'd31;
                o_wr_en        = 1'b1;
                o_jump         = 1'b1;
                o_link         = 1'b1;
                ctrl.src_a_sel = SRC_A_PC;
                ctrl.agu_pc    = 1'b1;
            end
            default: o_illegal = 1'b1;
        endcase

        // Unknown encodings issue as a no-op
        if (o_illegal) begin
            o_rd_dest      = 5'd0;
            o_alu_op       = ALU_PASS;
            o_wr_en        = 1'b0;
            o_jump         = 1'b0;
            ctrl.src_a_sel = SRC_A_ZERO;
            ctrl.src_b_sa  = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- id_register_file.sv
`include "id_config.svh"
`default_nettype none

module id_register_file (
    input  wire                              i_clk,
    input  wire                              i_rst_n,
    input  wire  [$clog2(`ID_REG_COUNT)-1:0] i_rs_sel,
    input  wire  [$clog2(`ID_REG_COUNT)-1:0] i_rt_sel,
    input  wire                              i_wr_en,
    input  wire  [$clog2(`ID_REG_COUNT)-1:0] i_wr_sel,
    input  wire  [`ID_DATA_W-1:0]            i_wr_data,
    output logic [`ID_DATA_W-1:0]            o_rs_data,
    output logic [`ID_DATA_W-1:0]            o_rt_data
);

    logic [`ID_DATA_W-1:0] regs [`ID_REG_COUNT];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `ID_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_sel != '0)) begin   // Register 0 stays zero
            regs[i_wr_sel] <= i_wr_data;
        end
    end

    // No write-through; new data shows the cycle after the edge
    assign o_rs_data = regs[i_rs_sel];
    assign o_rt_data = regs[i_rt_sel];

endmodule

`default_nettype wire

//--- id_operand_select.sv
`include "id_config.svh"
`default_nettype none

module id_operand_select import id_pkg::*; (
    id_ctrl_if.sel                sel,
    input  wire  [`ID_DATA_W-1:0] i_pc,
    input  wire  [`ID_DATA_W-1:0] i_rs_data,
    input  wire  [`ID_DATA_W-1:0] i_rt_data,
    output logic [`ID_DATA_W-1:0] o_alu_a,
    output logic [`ID_DATA_W-1:0] o_alu_b,
    output logic [`ID_DATA_W-1:0] o_agu_addr
);

    localparam int PAD_W = `ID_DATA_W - 16;

    logic [`ID_DATA_W-1:0] imm_ext;

    always_comb begin
        case (sel.ext_mode)
            EXT_ZERO:  imm_ext = {{PAD_W{1'b0}}, sel.imm};
            EXT_SIGN:  imm_ext = {{PAD_W{sel.imm[15]}}, sel.imm};
            EXT_UPPER: imm_ext = {sel.imm, {PAD_W{1'b0}}};   // LUI
            default:   imm_ext = '0;
        endcase
    end

    always_comb begin
        case (sel.src_a_sel)
            SRC_A_PC:  o_alu_a = i_pc;
            SRC_A_RS:  o_alu_a = i_rs_data;
            SRC_A_IMM: o_alu_a = imm_ext;
            default:   o_alu_a = '0;
        endcase
    end

    assign o_alu_b    = sel.src_b_sa ? {{(`ID_DATA_W-5){1'b0}}, sel.sa} : i_rt_data;
    assign o_agu_addr = sel.agu_pc ? i_pc : i_rs_data;   // PC for branches and J/JAL

endmodule

`default_nettype wire

//--- id_issue_reg.sv
`include "id_config.svh"
`default_nettype none

module id_issue_reg import id_pkg::*; (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_accept,
    input  wire        id_bundle_t i_bundle,
    input  wire        i_credit,
    output logic       o_ready,
    output logic       o_valid,
    output id_bundle_t o_bundle
);

    localparam int CNT_W = $clog2(`ID_CREDITS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`ID_CREDITS);

    logic [CNT_W-1:0] credit_cnt;

    // Accept and return in one cycle leave the count alone
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credit_cnt <= CNT_MAX;
        end else begin
            case ({i_accept, i_credit})
                2'b10: begin
                    credit_cnt <= credit_cnt - 1'b1;
                end
                2'b01: begin
                    if (credit_cnt < CNT_MAX) begin   // Saturate at full depth
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                default: begin
                    credit_cnt <= credit_cnt;
                end
            endcase
        end
    end

    assign o_ready = (credit_cnt != '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid  <= 1'b0;
            o_bundle <= '0;
        end else begin
            o_valid <= i_accept;   // One pulse per accepted instruction
            if (i_accept) begin
                o_bundle <= i_bundle;
            end
        end
    end

endmodule

`default_nettype wire

//--- id_stage_top.sv
`include "id_config.svh"
`default_nettype none

module id_stage_top import id_pkg::*; (
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire                   i_valid,
    input  wire  [`ID_DATA_W-1:0] i_pc,
    input  wire  [31:0]           i_instr,
    output logic                  o_ready,
    input  wire                   i_wb_en,
    input  wire  [4:0]            i_wb_sel,
    input  wire  [`ID_DATA_W-1:0] i_wb_data,
    input  wire                   i_credit,
    output logic                  o_valid,
    output logic [3:0]            o_alu_op,
    output logic [`ID_DATA_W-1:0] o_alu_a,
    output logic [`ID_DATA_W-1:0] o_alu_b,
    output logic [`ID_DATA_W-1:0] o_agu_addr,
    output logic [25:0]           o_addr_offset,
    output logic [4:0]            o_dest,
    output logic                  o_wr_en,
    output logic                  o_mem_rd,
    output logic                  o_mem_wr,
    output logic                  o_branch,
    output logic                  o_branch_ne,
    output logic                  o_jump,
    output logic                  o_link,
    output logic                  o_illegal
);

    logic [4:0]            rd_dest;
    alu_op_e               alu_op;
    logic                  wr_en;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  branch;
    logic                  branch_ne;
    logic                  jump;
    logic                  link;
    logic                  illegal;
    logic [25:0]           addr_offset;
    logic [`ID_DATA_W-1:0] rs_data;
    logic [`ID_DATA_W-1:0] rt_data;
    logic [`ID_DATA_W-1:0] alu_a;
    logic [`ID_DATA_W-1:0] alu_b;
    logic [`ID_DATA_W-1:0] agu_addr;
    logic                  accept;
    id_bundle_t            bundle;
    id_bundle_t            issued;

    id_ctrl_if ctrl_if ();

    id_control_unit u_ctrl (
        .i_instr       (i_instr),
        .ctrl          (ctrl_if.ctrl),
        .o_rd_dest     (rd_dest),
        .o_alu_op      (alu_op),
        .o_wr_en       (wr_en),
        .o_mem_rd      (mem_rd),
        .o_mem_wr      (mem_wr),
        .o_branch      (branch),
        .o_branch_ne   (branch_ne),
        .o_jump        (jump),
        .o_link        (link),
        .o_illegal     (illegal),
        .o_addr_offset (addr_offset)
    );

    id_register_file u_regs (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs_sel  (ctrl_if.rs),
        .i_rt_sel  (ctrl_if.rt),
        .i_wr_en   (i_wb_en),     // Write-back from the last stage
        .i_wr_sel  (i_wb_sel),
        .i_wr_data (i_wb_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    id_operand_select u_opsel (
        .sel        (ctrl_if.sel),
        .i_pc       (i_pc),
        .i_rs_data  (rs_data),
        .i_rt_data  (rt_data),
        .o_alu_a    (alu_a),
        .o_alu_b    (alu_b),
        .o_agu_addr (agu_addr)
    );

    assign accept = i_valid & o_ready;

    assign bundle = '{
        alu_op:      alu_op,
        alu_a:       alu_a,
        alu_b:       alu_b,
        agu_addr:    agu_addr,
        addr_offset: addr_offset,
        dest:        rd_dest,
        wr_en:       wr_en,
        mem_rd:      mem_rd,
        mem_wr:      mem_wr,
        branch:      branch,
        branch_ne:   branch_ne,
        jump:        jump,
        link:        link,
        illegal:     illegal
    };

    id_issue_reg u_issue (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_accept (accept),
        .i_bundle (bundle),
        .i_credit (i_credit),
        .o_ready  (o_ready),
        .o_valid  (o_valid),
        .o_bundle (issued)
    );

    assign o_alu_op      = issued.alu_op;
    assign o_alu_a       = issued.alu_a;
    assign o_alu_b       = issued.alu_b;
    assign o_agu_addr    = issued.agu_addr;
    assign o_addr_offset = issued.addr_offset;
    assign o_dest        = issued.dest;
    assign o_wr_en       = issued.wr_en;
    assign o_mem_rd      = issued.mem_rd;
    assign o_mem_wr      = issued.mem_wr;
    assign o_branch      = issued.branch;
    assign o_branch_ne   = issued.branch_ne;
    assign o_jump        = issued.jump;
    assign o_link        = issued.link;
    assign o_illegal     = issued.illegal;

endmodule

`default_nettype wire

//--- id_stage_asserts.sv
`include "id_config.svh"
`default_nettype none

module id_stage_asserts (
    input wire                               i_clk,
    input wire                               i_rst_n,
    input wire                               i_accept,
    input wire                               i_credit,
    input wire                               i_valid,
    input wire [$clog2(`ID_CREDITS + 1)-1:0] i_credit_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    accept_needs_credit: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_accept |-> (i_credit_cnt != '0)
    ) else $error("Instruction accepted with an empty credit pool");

    credit_cnt_bounded: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_credit_cnt <= `ID_CREDITS
    ) else $error("Credit count above its depth");

    // Issued bundle needs an acceptance that used up a credit
    valid_after_accept: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> $past(i_accept)
                    && ((i_credit_cnt < $past(i_credit_cnt)) || $past(i_credit))
    ) else $error("o_valid without a credit-consuming acceptance one cycle earlier");

endmodule

`default_nettype wire

//--- id_stage_tb.sv
`include "id_config.svh"
`default_nettype none

module id_stage_tb import id_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 20;   // Cycles before a wait gives up

    logic        i_clk;
    logic        i_rst_n;
    logic        i_valid;
    logic [31:0] i_pc;
    logic [31:0] i_instr;
    logic        o_ready;
    logic        i_wb_en;
    logic [4:0]  i_wb_sel;
    logic [31:0] i_wb_data;
    logic        i_credit;
    logic        o_valid;
    logic [3:0]  o_alu_op;
    logic [31:0] o_alu_a;
    logic [31:0] o_alu_b;
    logic [31:0] o_agu_addr;
    logic [25:0] o_addr_offset;
    logic [4:0]  o_dest;
    logic        o_wr_en;
    logic        o_mem_rd;
    logic        o_mem_wr;
    logic        o_branch;
    logic        o_branch_ne;
    logic        o_jump;
    logic        o_link;
    logic        o_illegal;

    logic [31:0] shadow [32];   // Register contents as written by the testbench
    logic [31:0] lfsr_state;
    string       test_name;
    int          error_count;
    id_bundle_t  seen [$];      // Bundles in arrival order
    id_bundle_t  expq [$];

    id_stage_top DUT (.*);

    bind id_issue_reg id_stage_asserts u_asserts (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_accept     (i_accept),
        .i_credit     (i_credit),
        .i_valid      (o_valid),
        .i_credit_cnt (credit_cnt)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [31:0] rs, input logic [31:0] rt,
                                          input logic [31:0] rd, input logic [31:0] sa,
                                          input logic [31:0] fn);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn[5:0]};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] op, input logic [31:0] rs,
                                          input logic [31:0] rt, input logic [31:0] imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] op, input logic [31:0] target);
        return {op[5:0], target[25:0]};
    endfunction

    // Expected bundle from the decode rules and the shadow registers
    function automatic id_bundle_t model(input logic [31:0] instr, input logic [31:0] pc);
        id_bundle_t  b;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] upper;
        op         = instr[31:26];
        fn         = instr[5:0];
        rs         = instr[25:21];
        rt         = instr[20:16];
        sext       = {{16{instr[15]}}, instr[15:0]};
        zext       = {16'h0000, instr[15:0]};
        upper      = {instr[15:0], 16'h0000};
        b          = '0;
        b.alu_op   = ALU_PASS;
        b.alu_a    = shadow[rs];
        b.alu_b    = shadow[rt];
        b.agu_addr = shadow[rs];
        b.dest     = rt;
        b.addr_offset = instr[25:0];
        case (op)
            6'h00: begin
                b.dest  = instr[15:11];
                b.wr_en = 1'b1;
                case (fn)
                    6'h21: b.alu_op = ALU_ADD;
                    6'h23: b.alu_op = ALU_SUB;
                    6'h24: b.alu_op = ALU_AND;
                    6'h25: b.alu_op = ALU_OR;
                    6'h26: b.alu_op = ALU_XOR;
                    6'h2a: b.alu_op = ALU_SLT;
                    6'h00: begin
                        b.alu_op = ALU_SLL;
                        b.alu_b  = {27'd0, instr[10:6]};
                    end
                    6'h02: begin
                        b.alu_op = ALU_SRL;
                        b.alu_b  = {27'd0, instr[10:6]};
                    end
                    6'h08: begin
                        b.wr_en = 1'b0;
                        b.jump  = 1'b1;   // Target travels on agu_addr
                        b.alu_a = '0;
                    end
                    default: b.illegal = 1'b1;
                endcase
            end
            6'h09: begin
                b.alu_op = ALU_ADD;
                b.alu_a  = sext;
                b.wr_en  = 1'b1;
            end
            6'h0c: begin
                b.alu_op = ALU_AND;
                b.alu_a  = zext;
                b.wr_en  = 1'b1;
            end
            6'h0d: begin
                b.alu_op = ALU_OR;
                b.alu_a  = zext;
                b.wr_en  = 1'b1;
            end
            6'h0f: begin
                b.alu_op = ALU_LUI;
                b.alu_a  = upper;
                b.wr_en  = 1'b1;
            end
            6'h23: begin
                b.alu_op = ALU_ADD;
                b.alu_a  = sext;
                b.wr_en  = 1'b1;
                b.mem_rd = 1'b1;
            end
            6'h2b: begin
                b.alu_op = ALU_ADD;
                b.alu_a  = sext;
                b.mem_wr = 1'b1;
            end
            6'h04, 6'h05: begin
                b.alu_op    = ALU_SUB;
                b.branch    = 1'b1;
                b.branch_ne = (op == 6'h05);
                b.agu_addr  = pc;
            end
            6'h02: begin
                b.dest     = 5'd0;
                b.jump     = 1'b1;
                b.alu_a    = '0;
                b.agu_addr = pc;
            end
            6'h03: begin
                b.dest     = 5'd31;
                b.wr_en    = 1'b1;
                b.jump     = 1'b1;
                b.link     = 1'b1;
                b.alu_a    = pc;   // Return address source
                b.agu_addr = pc;
            end
            default: b.illegal = 1'b1;
        endcase
        if (b.illegal) begin
            b.dest   = 5'd0;
            b.alu_op = ALU_PASS;
            b.wr_en  = 1'b0;
            b.jump   = 1'b0;
            b.alu_a  = '0;
        end
        return b;
    endfunction

    function automatic id_bundle_t capture_outputs();
        id_bundle_t b;
        b.alu_op      = alu_op_e'(o_alu_op);
        b.alu_a       = o_alu_a;
        b.alu_b       = o_alu_b;
        b.agu_addr    = o_agu_addr;
        b.addr_offset = o_addr_offset;
        b.dest        = o_dest;
        b.wr_en       = o_wr_en;
        b.mem_rd      = o_mem_rd;
        b.mem_wr      = o_mem_wr;
        b.branch      = o_branch;
        b.branch_ne   = o_branch_ne;
        b.jump        = o_jump;
        b.link        = o_link;
        b.illegal     = o_illegal;
        return b;
    endfunction

    always @(negedge i_clk) begin
        if (o_valid) begin
            seen.push_back(capture_outputs());
        end
    end

    task automatic end_with_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on failure");
    endtask

    task automatic check(input string what, input logic [31:0] want, input logic [31:0] act);
        if (want !== act) begin
            error_count++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, want, act);
            end_with_failure();
        end
    endtask

    task automatic compare_bundle(input id_bundle_t want, input id_bundle_t got);
        check("alu_op", 32'(want.alu_op), 32'(got.alu_op));
        check("alu_a", want.alu_a, got.alu_a);
        check("alu_b", want.alu_b, got.alu_b);
        check("agu_addr", want.agu_addr, got.agu_addr);
        check("addr_offset", 32'(want.addr_offset), 32'(got.addr_offset));
        check("dest", 32'(want.dest), 32'(got.dest));
        check("wr_en", 32'(want.wr_en), 32'(got.wr_en));
        check("mem_rd", 32'(want.mem_rd), 32'(got.mem_rd));
        check("mem_wr", 32'(want.mem_wr), 32'(got.mem_wr));
        check("branch", 32'(want.branch), 32'(got.branch));
        check("branch_ne", 32'(want.branch_ne), 32'(got.branch_ne));
        check("jump", 32'(want.jump), 32'(got.jump));
        check("link", 32'(want.link), 32'(got.link));
        check("illegal", 32'(want.illegal), 32'(got.illegal));
    endtask

    task automatic write_reg(input logic [4:0] sel, input logic [31:0] data);
        @(posedge i_clk);
        i_wb_en   <= 1'b1;
        i_wb_sel  <= sel;
        i_wb_data <= data;
        if (sel != 5'd0) begin
            shadow[sel] = data;
        end
        @(posedge i_clk);
        i_wb_en <= 1'b0;
    endtask

    // Present one instruction and hold it until the edge that accepts it
    task automatic send(input logic [31:0] instr, input logic [31:0] pc);
        int n;
        n = 0;
        @(posedge i_clk);
        i_valid <= 1'b1;
        i_instr <= instr;
        i_pc    <= pc;
        @(negedge i_clk);
        while (!o_ready) begin
            n++;
            if (n > WAIT_LIMIT) begin
                $display("%s: o_ready never rose for a pending instruction", test_name);
                end_with_failure();
            end
            @(negedge i_clk);
        end
        @(posedge i_clk);
        i_valid <= 1'b0;
    endtask

    task automatic wait_bundle(output id_bundle_t got);
        int n;
        n = 0;
        while (seen.size() == 0) begin
            n++;
            if (n > WAIT_LIMIT) begin
                $display("%s: no o_valid after an accepted instruction", test_name);
                end_with_failure();
            end
            @(negedge i_clk);
        end
        got = seen.pop_front();
    endtask

    task automatic give_credit();
        @(posedge i_clk);
        i_credit <= 1'b1;
        @(posedge i_clk);
        i_credit <= 1'b0;
    endtask

    task automatic issue_and_check(input logic [31:0] instr, input logic [31:0] pc);
        id_bundle_t want;
        id_bundle_t got;
        want = model(instr, pc);
        send(instr, pc);
        wait_bundle(got);
        compare_bundle(want, got);
        give_credit();
    endtask

    task automatic test_reset();
        test_name = "reset";
        @(negedge i_clk);
        check("o_valid", 0, 32'(o_valid));
        check("o_ready", 1, 32'(o_ready));
        for (int r = 0; r < 32; r++) begin
            issue_and_check(enc_r(r, r, 1, 0, 32'h21), 32'h100 + 4 * r);
        end
    endtask

    task automatic test_writeback();
        test_name = "writeback";
        for (int r = 1; r < 32; r++) begin
            write_reg(5'(r), rand_bits(32));
        end
        write_reg(5'd0, rand_bits(32));   // Must be dropped
        for (int r = 0; r < 32; r++) begin
            issue_and_check(enc_r(r, 31 - r, 2, 0, 32'h21), 32'h200);
        end
    endtask

    task automatic test_rtype();
        logic [31:0] fns [9];
        test_name = "rtype";
        fns = '{32'h21, 32'h23, 32'h24, 32'h25, 32'h26, 32'h2a, 32'h00, 32'h02, 32'h08};
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 9; k++) begin
                issue_and_check(enc_r(rand_bits(5), rand_bits(5), rand_bits(5), rand_bits(5),
                                      fns[k]), rand_bits(32));
            end
        end
    endtask

    task automatic test_itype();
        logic [31:0] ops [8];
        test_name = "itype";
        ops = '{32'h09, 32'h0c, 32'h0d, 32'h0f, 32'h23, 32'h2b, 32'h04, 32'h05};
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 8; k++) begin
                // Second round sets imm[15]
                issue_and_check(enc_i(ops[k], rand_bits(5), rand_bits(5),
                                      {1'(round), 15'(rand_bits(15))}),
                                rand_bits(32));
            end
            issue_and_check(enc_j(32'h02, rand_bits(26)), rand_bits(32));
            issue_and_check(enc_j(32'h03, rand_bits(26)), rand_bits(32));
            issue_and_check(enc_r(rand_bits(5), 0, 0, 0, 32'h08), rand_bits(32));
        end
    endtask

    task automatic test_backpressure();
        logic [31:0] instr;
        id_bundle_t  got;
        int          n;
        test_name = "backpressure";
        for (int k = 0; k < `ID_CREDITS; k++) begin
            instr = enc_r(k + 1, k + 2, k + 3, 0, 32'h25);
            expq.push_back(model(instr, 32'h300));
            send(instr, 32'h300);
        end
        instr = enc_i(32'h09, 3, 4, 32'h1234);
        expq.push_back(model(instr, 32'h304));
        @(posedge i_clk);
        i_valid <= 1'b1;   // Held while the pool is empty
        i_instr <= instr;
        i_pc    <= 32'h304;
        repeat (4) begin
            @(negedge i_clk);
            check("o_ready without credits", 0, 32'(o_ready));
        end
        check("bundles before credit return", `ID_CREDITS, 32'(seen.size()));
        give_credit();
        n = 0;
        @(negedge i_clk);
        while (!o_ready) begin
            n++;
            if (n > WAIT_LIMIT) begin
                $display("%s: o_ready stayed low after a returned credit", test_name);
                end_with_failure();
            end
            @(negedge i_clk);
        end
        @(posedge i_clk);
        i_valid <= 1'b0;
        repeat (3) begin
            @(negedge i_clk);
            check("o_ready after one credit", 0, 32'(o_ready));
        end
        check("bundles after one credit", `ID_CREDITS + 1, 32'(seen.size()));
        while (expq.size() > 0) begin
            got = seen.pop_front();
            compare_bundle(expq.pop_front(), got);
        end
        repeat (`ID_CREDITS) give_credit();
        @(negedge i_clk);
        check("o_ready after refill", 1, 32'(o_ready));
    endtask

    task automatic test_illegal();
        test_name = "illegal";
        issue_and_check(enc_i(32'h3f, rand_bits(5), rand_bits(5), rand_bits(16)), rand_bits(32));
        issue_and_check(enc_i(32'h01, rand_bits(5), rand_bits(5), rand_bits(16)), rand_bits(32));
        issue_and_check(enc_r(rand_bits(5), rand_bits(5), rand_bits(5), 0, 32'h3f),
                        rand_bits(32));
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_valid     = 1'b0;
        i_pc        = '0;
        i_instr     = '0;
        i_wb_en     = 1'b0;
        i_wb_sel    = '0;
        i_wb_data   = '0;
        i_credit    = 1'b0;
        lfsr_state  = 32'd13;
        error_count = 0;
        test_name   = "init";
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;

        test_reset();
        test_writeback();
        test_rtype();
        test_itype();
        test_backpressure();
        test_illegal();

        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            end_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
id_pkg.sv
id_ctrl_if.sv
id_control_unit.sv
id_register_file.sv
id_operand_select.sv
id_issue_reg.sv
id_stage_top.sv
id_stage_asserts.sv
id_stage_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module id_stage_tb -f list.f -o id_stage_sim \
    && ./obj_dir/id_stage_sim > sim.log 2>&1 || echo "build or simulation did not complete" >> sim.log
cat sim.log
! grep -q "Finished with errors" sim.log && grep -q "Finished with no errors" sim.log
